// ==== build.f ====
+incdir+common
+incdir+testbench
common/nand_cpu_pkg.sv
common/nand_cpu_ifc.sv
fetch/fetch_unit.sv
fetch/instr_queue.sv
execute/reg_file.sv
execute/decode_stage.sv
execute/action_stage.sv
rtl/nand_cpu_core.sv
testbench/nand_cpu_tb.sv

// ==== common/nand_cpu_consts.svh ====
`ifndef NAND_CPU_CONSTS_SVH
`define NAND_CPU_CONSTS_SVH

// ************************************************************************
// core sizes.
// ************************************************************************

// program counter width.
`define PC_SIZE 16

// default number of entries in the instruction queue.
`define QUEUE_DEPTH 4

// data memory words, addressed by the low bits of rt.
`define DMEM_WORDS 32

// general purpose registers, r0 is the fixed first operand.
`define REG_COUNT 16

`endif

// ==== common/nand_cpu_ifc.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

// stamped instruction, valid/ready handshake.
interface pr_pass_ifc
    import nand_cpu_pkg::*;
();
    logic                   valid;
    logic                   ready;
    logic [`PC_SIZE - 1:0]  pc;
    instr_u                 instr;

    modport out (output valid, output pc, output instr, input ready);
    modport in (input valid, input pc, input instr, output ready);
endinterface

// decode to action stage, no back-pressure.
interface act_pass_ifc
    import nand_cpu_pkg::*;
();
    logic                   valid;
    opcode_e                opcode;
    word_t                  op0;
    word_t                  op1;
    logic                   reg_write;
    reg_addr_t              reg_addr;
    logic                   ps_write;
    logic [`PC_SIZE - 1:0]  pc;
    logic                   link;

    modport out (output valid, output opcode, output op0, output op1, output reg_write,
                 output reg_addr, output ps_write, output pc, output link);
    modport in (input valid, input opcode, input op0, input op1, input reg_write,
                input reg_addr, input ps_write, input pc, input link);
endinterface

// result bundle used for forwarding and writeback.
interface forward_data_ifc
    import nand_cpu_pkg::*;
();
    logic       use_rw;
    reg_addr_t  rw_addr;
    word_t      rw_data;
    logic       write_ps;
    logic       ps_data;

    modport out (output use_rw, output rw_addr, output rw_data, output write_ps, output ps_data);
    modport in (input use_rw, input rw_addr, input rw_data, input write_ps, input ps_data);
endinterface

// ==== common/nand_cpu_pkg.sv ====
package nand_cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // values 9 to 15 are not listed and run as no-ops.
    typedef enum logic [3:0] {
        OP_NAND = 4'd0,
        OP_ADD  = 4'd1,
        OP_TEQ  = 4'd2,
        OP_LI   = 4'd3,
        OP_LD   = 4'd4,
        OP_ST   = 4'd5,
        OP_BR   = 4'd6,
        OP_JMP  = 4'd7,
        OP_HALT = 4'd8
    } opcode_e;

    // register form.
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rw_addr;
        reg_addr_t rt_addr;
        logic [3:0] spare;
    } r_form_t;

    // immediate form, only LI reads the immediate.
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rw_addr;
        logic [7:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_u;

endpackage

// ==== execute/action_stage.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module action_stage
    import nand_cpu_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset,
    act_pass_ifc.in         i_act_pass,
    forward_data_ifc.out    o_a_forward,
    forward_data_ifc.out    o_w_forward
);

localparam int DMEM_AW = $clog2(`DMEM_WORDS);

word_t dmem [`DMEM_WORDS];
logic [DMEM_AW - 1:0] mem_addr;
word_t mem_rdata;
logic store;
word_t alu_result;
word_t link_value;
word_t rw_data;
logic use_rw;
logic write_ps;
logic ps_data;

// ************************************************************************
// ALU.
// ************************************************************************
always_comb begin
    case (i_act_pass.opcode)
        OP_NAND: alu_result = ~(i_act_pass.op0 & i_act_pass.op1);
        OP_ADD:  alu_result = i_act_pass.op0 + i_act_pass.op1;
        default: alu_result = i_act_pass.op1;
    endcase
end

assign ps_data = (i_act_pass.op0 == i_act_pass.op1);

// data memory, rt gives the address and r0 the store data.
assign mem_addr  = i_act_pass.op1[DMEM_AW - 1:0];
assign mem_rdata = dmem[mem_addr];
assign store     = i_act_pass.valid & (i_act_pass.opcode == OP_ST);

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            dmem[i] <= '0;
        end
    end else if (store) begin
        dmem[mem_addr] <= i_act_pass.op0;
    end
end

// ************************************************************************
// result select and forwarding.
// ************************************************************************
assign link_value = word_t'(i_act_pass.pc + 1'b1);
assign rw_data    = i_act_pass.link ? link_value :
                    (i_act_pass.opcode == OP_LD) ? mem_rdata : alu_result;
assign use_rw     = i_act_pass.valid & i_act_pass.reg_write;
assign write_ps   = i_act_pass.valid & i_act_pass.ps_write;

assign o_a_forward.use_rw   = use_rw;
assign o_a_forward.rw_addr  = i_act_pass.reg_addr;
assign o_a_forward.rw_data  = rw_data;
assign o_a_forward.write_ps = write_ps;
assign o_a_forward.ps_data  = ps_data;

// writeback register.
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_w_forward.use_rw   <= 1'b0;
        o_w_forward.write_ps <= 1'b0;
    end else begin
        o_w_forward.use_rw   <= use_rw;
        o_w_forward.write_ps <= write_ps;
    end
end

always_ff @(posedge i_clk) begin
    o_w_forward.rw_addr <= i_act_pass.reg_addr;
    o_w_forward.rw_data <= rw_data;
    o_w_forward.ps_data <= ps_data;
end

endmodule

// ==== execute/decode_stage.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module decode_stage
    import nand_cpu_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    pr_pass_ifc.in                  i_pr_pass,
    forward_data_ifc.in             i_a_forward,
    forward_data_ifc.in             i_w_forward,
    output reg_addr_t               o_ra_addr,
    output reg_addr_t               o_rt_addr,
    input  word_t                   i_ra_data,
    input  word_t                   i_rt_data,
    input  logic                    i_ps,
    act_pass_ifc.out                o_act_pass,
    output logic                    o_branch_valid,
    output logic                    o_branch_taken,
    output logic [`PC_SIZE - 1:0]   o_branch_target,
    output logic                    o_halted
);

localparam int PC_W = `PC_SIZE;
localparam reg_addr_t RA_ADDR = '0;

opcode_e opcode;
logic fire;
word_t ra_data;
word_t rt_data;
logic ps_data;
logic use_rw;
logic is_ctrl;
logic taken;
logic [PC_W - 1:0] target;

assign opcode = i_pr_pass.instr.r.opcode;
assign fire   = i_pr_pass.valid & i_pr_pass.ready;

// halt is sticky, nothing leaves the queue after it.
assign i_pr_pass.ready = ~o_halted;

assign o_ra_addr = RA_ADDR;
assign o_rt_addr = i_pr_pass.instr.r.rt_addr;

// ************************************************************************
// operand forwarding, a-stage first, then w-stage, then register file.
// ************************************************************************
always_comb begin
    if (i_a_forward.use_rw && (i_a_forward.rw_addr == RA_ADDR)) begin
        ra_data = i_a_forward.rw_data;
    end else if (i_w_forward.use_rw && (i_w_forward.rw_addr == RA_ADDR)) begin
        ra_data = i_w_forward.rw_data;
    end else begin
        ra_data = i_ra_data;
    end

    if (i_a_forward.use_rw && (i_a_forward.rw_addr == o_rt_addr)) begin
        rt_data = i_a_forward.rw_data;
    end else if (i_w_forward.use_rw && (i_w_forward.rw_addr == o_rt_addr)) begin
        rt_data = i_w_forward.rw_data;
    end else begin
        rt_data = i_rt_data;
    end

    if (i_a_forward.write_ps) begin
        ps_data = i_a_forward.ps_data;
    end else if (i_w_forward.write_ps) begin
        ps_data = i_w_forward.ps_data;
    end else begin
        ps_data = i_ps;
    end
end

assign use_rw = (opcode == OP_NAND) || (opcode == OP_ADD) || (opcode == OP_LI) ||
                (opcode == OP_LD) || (opcode == OP_JMP);
assign is_ctrl = (opcode == OP_BR) || (opcode == OP_JMP);

// branch resolution.
assign taken  = (opcode == OP_JMP) || ((opcode == OP_BR) && ps_data);
assign target = (opcode == OP_JMP) ? PC_W'(rt_data) :
                taken ? i_pr_pass.pc + PC_W'(rt_data) : i_pr_pass.pc + 1'b1;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_act_pass.valid     <= 1'b0;
        o_act_pass.reg_write <= 1'b0;
        o_act_pass.ps_write  <= 1'b0;
        o_branch_valid       <= 1'b0;
        o_halted             <= 1'b0;
    end else begin
        o_act_pass.valid     <= fire;
        o_act_pass.reg_write <= fire & use_rw;
        o_act_pass.ps_write  <= fire & (opcode == OP_TEQ);
        o_branch_valid       <= fire & is_ctrl;
        o_halted             <= o_halted | (fire & (opcode == OP_HALT));
    end
end

always_ff @(posedge i_clk) begin
    o_act_pass.opcode   <= opcode;
    o_act_pass.op0      <= ra_data;
    o_act_pass.op1      <= (opcode == OP_LI) ? {8'h00, i_pr_pass.instr.i.imm} : rt_data;
    o_act_pass.reg_addr <= i_pr_pass.instr.r.rw_addr;
    o_act_pass.pc       <= i_pr_pass.pc;
    o_act_pass.link     <= (opcode == OP_JMP);
    o_branch_taken      <= taken;
    o_branch_target     <= target;
end

endmodule

// ==== execute/reg_file.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module reg_file
    import nand_cpu_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  reg_addr_t   i_ra_addr,
    input  reg_addr_t   i_rt_addr,
    output word_t       o_ra_data,
    output word_t       o_rt_data,
    output logic        o_ps,
    forward_data_ifc.in i_w_forward
);

word_t regs [`REG_COUNT];
logic ps;

assign o_ra_data = regs[i_ra_addr];
assign o_rt_data = regs[i_rt_addr];
assign o_ps      = ps;

// writes come from the writeback bundle.
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
        end
        ps <= 1'b0;
    end else begin
        if (i_w_forward.use_rw) begin
            regs[i_w_forward.rw_addr] <= i_w_forward.rw_data;
        end
        if (i_w_forward.write_ps) begin
            ps <= i_w_forward.ps_data;
        end
    end
end

endmodule

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module fetch_unit
    import nand_cpu_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_instr_valid,
    input  instr_u                  i_instr,
    output logic                    o_instr_ready,
    pr_pass_ifc.out                 o_pr_pass,
    input  logic                    i_branch_valid,
    input  logic [`PC_SIZE - 1:0]   i_branch_target
);

logic [`PC_SIZE - 1:0] pc;
logic running;
logic hold;
logic is_ctrl;
logic accept;

// predecode, a branch or jump stops the stream until decode resolves it.
assign is_ctrl = (i_instr.r.opcode == OP_BR) || (i_instr.r.opcode == OP_JMP);

assign o_pr_pass.valid = i_instr_valid & running & ~hold;
assign o_pr_pass.pc    = pc;
assign o_pr_pass.instr = i_instr;
assign o_instr_ready   = o_pr_pass.ready & running & ~hold;
assign accept          = o_pr_pass.valid & o_pr_pass.ready;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        pc      <= '0;
        running <= 1'b0;
        hold    <= 1'b0;
    end else begin
        running <= 1'b1;
        if (i_branch_valid) begin
            pc   <= i_branch_target;
            hold <= 1'b0;
        end else if (accept) begin
            pc   <= pc + 1'b1;
            hold <= is_ctrl;
        end
    end
end

endmodule

// ==== fetch/instr_queue.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module instr_queue
    import nand_cpu_pkg::*;
#(
    parameter int DEPTH = `QUEUE_DEPTH
)(
    input  logic    i_clk,
    input  logic    i_reset,
    pr_pass_ifc.in  i_pr_pass,
    pr_pass_ifc.out o_pr_pass
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

logic [`PC_SIZE - 1:0] pc_mem [DEPTH];
instr_u instr_mem [DEPTH];

logic [PTR_W - 1:0] wr_ptr;
logic [PTR_W - 1:0] rd_ptr;
logic [CNT_W - 1:0] count;
logic wr_en;
logic rd_en;

assign i_pr_pass.ready = (count != CNT_W'(DEPTH));
assign o_pr_pass.valid = (count != '0);
assign o_pr_pass.pc    = pc_mem[rd_ptr];
assign o_pr_pass.instr = instr_mem[rd_ptr];

assign wr_en = i_pr_pass.valid & i_pr_pass.ready;
assign rd_en = o_pr_pass.valid & o_pr_pass.ready;

always_ff @(posedge i_clk) begin
    if (wr_en) begin
        pc_mem[wr_ptr]    <= i_pr_pass.pc;
        instr_mem[wr_ptr] <= i_pr_pass.instr;
    end
end

// pointers wrap at DEPTH so any depth works, not only powers of two.
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        if (wr_en && !rd_en) begin
            count <= count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
        end
    end
end

endmodule

// ==== rtl/nand_cpu_core.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module nand_cpu_core
    import nand_cpu_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_instr_valid,
    input  instr_u                  i_instr,
    output logic                    o_instr_ready,
    output logic                    o_wb_valid,
    output reg_addr_t               o_wb_addr,
    output word_t                   o_wb_data,
    output logic                    o_branch_valid,
    output logic                    o_branch_taken,
    output logic [`PC_SIZE - 1:0]   o_branch_target,
    output logic                    o_halted
);

pr_pass_ifc fetch_pass ();
pr_pass_ifc queue_pass ();
act_pass_ifc act_pass ();
forward_data_ifc a_forward ();
forward_data_ifc w_forward ();

reg_addr_t ra_addr;
reg_addr_t rt_addr;
word_t ra_data;
word_t rt_data;
logic ps;

// ************************************************************************
// producer, buffer and consumer.
// ************************************************************************
fetch_unit u_fetch (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_instr_valid   (i_instr_valid),
    .i_instr         (i_instr),
    .o_instr_ready   (o_instr_ready),
    .o_pr_pass       (fetch_pass),
    .i_branch_valid  (o_branch_valid),
    .i_branch_target (o_branch_target)
);

instr_queue #(.DEPTH(`QUEUE_DEPTH)) u_queue (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_pr_pass (fetch_pass),
    .o_pr_pass (queue_pass)
);

decode_stage u_decode (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_pr_pass       (queue_pass),
    .i_a_forward     (a_forward),
    .i_w_forward     (w_forward),
    .o_ra_addr       (ra_addr),
    .o_rt_addr       (rt_addr),
    .i_ra_data       (ra_data),
    .i_rt_data       (rt_data),
    .i_ps            (ps),
    .o_act_pass      (act_pass),
    .o_branch_valid  (o_branch_valid),
    .o_branch_taken  (o_branch_taken),
    .o_branch_target (o_branch_target),
    .o_halted        (o_halted)
);

reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_ra_addr   (ra_addr),
    .i_rt_addr   (rt_addr),
    .o_ra_data   (ra_data),
    .o_rt_data   (rt_data),
    .o_ps        (ps),
    .i_w_forward (w_forward)
);

action_stage u_action (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_act_pass  (act_pass),
    .o_a_forward (a_forward),
    .o_w_forward (w_forward)
);

// writes are reported as they enter the register file.
assign o_wb_valid = w_forward.use_rw;
assign o_wb_addr  = w_forward.rw_addr;
assign o_wb_data  = w_forward.rw_data;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the nand_cpu testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=nand_cpu_sim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal --top-module nand_cpu_tb \
    -f build.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG_FILE"; then
    exit 0
fi
exit 1

// ==== testbench/nand_cpu_tb_tests.svh ====
// ************************************************************************
// directed tests, each one ends with the pipeline drained and compared.
// ************************************************************************

// random immediates, then NAND and ADD across them.
task automatic test_alu_ops();
    for (int i = 0; i < 8; i++) begin
        issue(enc_i(OP_LI, reg_addr_t'(i), 8'($urandom())));
    end
    for (int i = 1; i < 8; i++) begin
        issue(enc_r(OP_NAND, reg_addr_t'(i + 7), reg_addr_t'(i)));
        issue(enc_r(OP_ADD, reg_addr_t'(i + 8), reg_addr_t'(i)));
    end
    drain_and_compare("alu ops");
endtask

// back to back chains through the a-stage and w-stage forwards.
task automatic test_forwarding();
    for (int round = 0; round < 3; round++) begin
        issue(enc_i(OP_LI, 4'd0, 8'($urandom())));
        issue(enc_r(OP_ADD, 4'd0, 4'd0));
        issue(enc_r(OP_NAND, 4'd10, 4'd0));
        issue(enc_r(OP_ADD, 4'd11, 4'd10));
        // r10 is two back here, so it comes from the w-stage.
        issue(enc_r(OP_ADD, 4'd12, 4'd10));
        issue(enc_i(OP_LI, 4'd13, 8'($urandom())));
        issue(enc_r(OP_NAND, 4'd0, 4'd12));
        issue(enc_r(OP_ADD, 4'd14, 4'd0));
    end
    drain_and_compare("forwarding");
endtask

// stores to random low addresses, address 31 stays untouched.
task automatic test_memory();
    logic [7:0] addr [4];
    for (int i = 0; i < 4; i++) begin
        addr[i] = 8'($urandom_range(15));
        issue(enc_i(OP_LI, 4'd2, addr[i]));
        issue(enc_i(OP_LI, 4'd1, 8'($urandom())));
        issue(enc_i(OP_LI, 4'd0, 8'($urandom())));
        issue(enc_r(OP_ADD, 4'd0, 4'd1));
        issue(enc_r(OP_NAND, 4'd0, 4'd0));
        issue(enc_r(OP_ST, 4'd0, 4'd2));
        issue(enc_r(OP_LD, 4'd3, 4'd2));
    end
    // read back in reverse, the last store to an address wins.
    for (int i = 3; i >= 0; i--) begin
        issue(enc_i(OP_LI, 4'd2, addr[i]));
        issue(enc_r(OP_LD, 4'd4, 4'd2));
    end
    issue(enc_i(OP_LI, 4'd2, 8'd31));
    issue(enc_r(OP_LD, 4'd5, 4'd2));
    drain_and_compare("memory");
endtask

// taken and not taken BR, then two JMPs whose links follow the PC.
task automatic test_branches();
    logic [7:0] value;
    value = 8'($urandom());
    issue(enc_i(OP_LI, 4'd1, value));
    issue(enc_i(OP_LI, 4'd0, value));
    issue(enc_i(OP_LI, 4'd2, 8'($urandom_range(40, 8))));
    // predicate comes from the a-stage.
    issue(enc_r(OP_TEQ, 4'd0, 4'd1));
    issue(enc_r(OP_BR, 4'd0, 4'd2));
    issue(enc_i(OP_LI, 4'd1, value ^ 8'h01));
    issue(enc_r(OP_TEQ, 4'd0, 4'd1));
    issue(enc_i(OP_LI, 4'd2, 8'd5));
    // predicate comes from the w-stage, and is clear.
    issue(enc_r(OP_BR, 4'd0, 4'd2));
    issue(enc_i(OP_LI, 4'd4, 8'($urandom_range(200, 100))));
    issue(enc_r(OP_JMP, 4'd3, 4'd4));
    issue(enc_i(OP_LI, 4'd5, 8'($urandom_range(90, 50))));
    issue(enc_r(OP_JMP, 4'd6, 4'd5));
    drain_and_compare("branches");
endtask

// halt stops writes, the queue fills and input ready stays low.
task automatic test_halt();
    int waited;
    int accepted;
    int late_ready;
    issue(enc_i(OP_LI, 4'd7, 8'($urandom())));
    issue(enc_r(OP_HALT, 4'd0, 4'd0));
    drain_and_compare("halt");
    waited = 0;
    while (o_halted !== 1'b1 && waited < DRAIN_LIMIT) begin
        @(negedge i_clk);
        waited++;
    end
    if (o_halted !== 1'b1) begin
        $display("Error at %0t ns: o_halted did not rise after HALT", $time);
        other_error_count++;
    end
    accepted = 0;
    late_ready = 0;
    i_instr = enc_i(OP_LI, 4'd1, 8'hff);
    i_instr_valid = 1'b1;
    for (int c = 0; c < `QUEUE_DEPTH + 12; c++) begin
        @(negedge i_clk);
        if (o_instr_ready === 1'b1) begin
            accepted++;
            if (c >= `QUEUE_DEPTH + 4) begin
                late_ready++;
            end
        end
    end
    @(posedge i_clk);
    #2;
    i_instr_valid = 1'b0;
    if (accepted > `QUEUE_DEPTH) begin
        $display("Error at %0t ns: %0d words accepted after HALT, more than the queue holds",
                 $time, accepted);
        other_error_count++;
    end
    if (late_ready != 0) begin
        $display("Error at %0t ns: o_instr_ready rose again after the queue filled", $time);
        other_error_count++;
    end
    if (obs_wb_addr.size() != 0) begin
        $display("Error at %0t ns: %0d register writes appeared after HALT",
                 $time, obs_wb_addr.size());
        other_error_count++;
    end
    obs_wb_addr.delete();
    obs_wb_data.delete();
endtask

// ==== testbench/nand_cpu_tb.sv ====
`timescale 1ns/100ps

`include "nand_cpu_consts.svh"

module nand_cpu_tb
    import nand_cpu_pkg::*;
();

localparam int CLK_PERIOD      = 40;
localparam int RESET_CYCLES    = 8;
localparam int WATCHDOG_CYCLES = 4000;
localparam int READY_LIMIT     = 24;
localparam int DRAIN_LIMIT     = 40;

typedef logic [`PC_SIZE - 1:0] pc_t;

logic       i_clk;
logic       i_reset;
logic       i_instr_valid;
instr_u     i_instr;
logic       o_instr_ready;
logic       o_wb_valid;
reg_addr_t  o_wb_addr;
word_t      o_wb_data;
logic       o_branch_valid;
logic       o_branch_taken;
pc_t        o_branch_target;
logic       o_halted;

int mismatch_count;
int other_error_count;

// reference model state.
word_t model_regs [`REG_COUNT];
logic  model_ps;
word_t model_mem [`DMEM_WORDS];
pc_t   model_pc;

reg_addr_t exp_wb_addr [$];
word_t     exp_wb_data [$];
logic      exp_br_taken [$];
pc_t       exp_br_target [$];
reg_addr_t obs_wb_addr [$];
word_t     obs_wb_data [$];
logic      obs_br_taken [$];
pc_t       obs_br_target [$];

nand_cpu_core i_dut (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_instr_valid   (i_instr_valid),
    .i_instr         (i_instr),
    .o_instr_ready   (o_instr_ready),
    .o_wb_valid      (o_wb_valid),
    .o_wb_addr       (o_wb_addr),
    .o_wb_data       (o_wb_data),
    .o_branch_valid  (o_branch_valid),
    .o_branch_taken  (o_branch_taken),
    .o_branch_target (o_branch_target),
    .o_halted        (o_halted)
);

initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_error_count);
    $display("Some tests failed");
    $finish;
end

// outputs settle half a cycle before the falling edge.
always @(negedge i_clk) begin
    if (!i_reset && o_wb_valid === 1'b1) begin
        obs_wb_addr.push_back(o_wb_addr);
        obs_wb_data.push_back(o_wb_data);
    end
    if (!i_reset && o_branch_valid === 1'b1) begin
        obs_br_taken.push_back(o_branch_taken);
        obs_br_target.push_back(o_branch_target);
    end
end

// ************************************************************************
// compare tasks.
// ************************************************************************
task automatic check_wb(input reg_addr_t exp_addr, input word_t exp_data,
                        input reg_addr_t act_addr, input word_t act_data);
    if (act_addr !== exp_addr) begin
        $display("Mismatch at %0t ns: o_wb_addr expected %0d, actual %0d",
                 $time, exp_addr, act_addr);
        mismatch_count++;
    end
    if (act_data !== exp_data) begin
        $display("Mismatch at %0t ns: o_wb_data expected 0x%04h, actual 0x%04h",
                 $time, exp_data, act_data);
        mismatch_count++;
    end
endtask

task automatic check_branch(input logic exp_taken, input pc_t exp_target,
                            input logic act_taken, input pc_t act_target);
    if (act_taken !== exp_taken) begin
        $display("Mismatch at %0t ns: o_branch_taken expected %0b, actual %0b",
                 $time, exp_taken, act_taken);
        mismatch_count++;
    end
    if (act_target !== exp_target) begin
        $display("Mismatch at %0t ns: o_branch_target expected 0x%04h, actual 0x%04h",
                 $time, exp_target, act_target);
        mismatch_count++;
    end
endtask

task automatic check_reset_outputs(input string when);
    if (o_instr_ready !== 1'b0 || o_wb_valid !== 1'b0 ||
        o_branch_valid !== 1'b0 || o_halted !== 1'b0) begin
        $display("Error at %0t ns: outputs are not all low %s", $time, when);
        other_error_count++;
    end
endtask

// ************************************************************************
// reference model.
// ************************************************************************
task automatic model_reset();
    for (int i = 0; i < `REG_COUNT; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < `DMEM_WORDS; i++) begin
        model_mem[i] = '0;
    end
    model_ps = 1'b0;
    model_pc = '0;
endtask

task automatic expect_write(input reg_addr_t addr, input word_t data);
    exp_wb_addr.push_back(addr);
    exp_wb_data.push_back(data);
    model_regs[addr] = data;
endtask

task automatic expect_branch(input logic taken, input pc_t target);
    exp_br_taken.push_back(taken);
    exp_br_target.push_back(target);
endtask

task automatic model_apply(input instr_u w);
    reg_addr_t rw;
    word_t     ra_val;
    word_t     rt_val;
    pc_t       next_pc;
    rw = w.r.rw_addr;
    ra_val = model_regs[0];
    rt_val = model_regs[w.r.rt_addr];
    next_pc = model_pc + 16'd1;
    case (w.r.opcode)
        OP_NAND: expect_write(rw, ~(ra_val & rt_val));
        OP_ADD:  expect_write(rw, ra_val + rt_val);
        OP_TEQ:  model_ps = (ra_val == rt_val);
        OP_LI:   expect_write(rw, {8'h00, w.i.imm});
        OP_LD:   expect_write(rw, model_mem[rt_val % `DMEM_WORDS]);
        OP_ST:   model_mem[rt_val % `DMEM_WORDS] = ra_val;
        OP_BR: begin
            if (model_ps) begin
                next_pc = model_pc + pc_t'(rt_val);
            end
            expect_branch(model_ps, next_pc);
        end
        OP_JMP: begin
            next_pc = pc_t'(rt_val);
            expect_write(rw, word_t'(model_pc + 16'd1));
            expect_branch(1'b1, next_pc);
        end
        default: begin
        end
    endcase
    model_pc = next_pc;
endtask

// ************************************************************************
// stimulus helpers start and end 2 ns after a rising edge.
// ************************************************************************
function automatic instr_u enc_r(input opcode_e op, input reg_addr_t rw, input reg_addr_t rt);
    instr_u w;
    w.r.opcode = op;
    w.r.rw_addr = rw;
    w.r.rt_addr = rt;
    w.r.spare = '0;
    return w;
endfunction

function automatic instr_u enc_i(input opcode_e op, input reg_addr_t rw, input logic [7:0] imm);
    instr_u w;
    w.i.opcode = op;
    w.i.rw_addr = rw;
    w.i.imm = imm;
    return w;
endfunction

task automatic send_instr(input instr_u w);
    int waited;
    waited = 0;
    i_instr = w;
    i_instr_valid = 1'b1;
    @(negedge i_clk);
    while (o_instr_ready !== 1'b1 && waited < READY_LIMIT) begin
        @(negedge i_clk);
        waited++;
    end
    if (o_instr_ready !== 1'b1) begin
        $display("Error at %0t ns: o_instr_ready stayed low for %0d cycles", $time, waited);
        other_error_count++;
    end
    @(posedge i_clk);
    #2;
    i_instr_valid = 1'b0;
endtask

task automatic issue(input instr_u w);
    model_apply(w);
    send_instr(w);
endtask

task automatic drain_and_compare(input string name);
    int waited;
    int n;
    waited = 0;
    while ((obs_wb_addr.size() < exp_wb_addr.size() ||
            obs_br_taken.size() < exp_br_taken.size()) && waited < DRAIN_LIMIT) begin
        @(negedge i_clk);
        waited++;
    end
    // a few more cycles so that extra writes show up.
    repeat (4) @(negedge i_clk);
    if (obs_wb_addr.size() != exp_wb_addr.size()) begin
        $display("Error at %0t ns: %s expected %0d register writes but saw %0d",
                 $time, name, exp_wb_addr.size(), obs_wb_addr.size());
        other_error_count++;
    end
    if (obs_br_taken.size() != exp_br_taken.size()) begin
        $display("Error at %0t ns: %s expected %0d branch reports but saw %0d",
                 $time, name, exp_br_taken.size(), obs_br_taken.size());
        other_error_count++;
    end
    n = (obs_wb_addr.size() < exp_wb_addr.size()) ? obs_wb_addr.size() : exp_wb_addr.size();
    for (int i = 0; i < n; i++) begin
        check_wb(exp_wb_addr[i], exp_wb_data[i], obs_wb_addr[i], obs_wb_data[i]);
    end
    n = (obs_br_taken.size() < exp_br_taken.size()) ? obs_br_taken.size() : exp_br_taken.size();
    for (int i = 0; i < n; i++) begin
        check_branch(exp_br_taken[i], exp_br_target[i], obs_br_taken[i], obs_br_target[i]);
    end
    exp_wb_addr.delete();
    exp_wb_data.delete();
    exp_br_taken.delete();
    exp_br_target.delete();
    obs_wb_addr.delete();
    obs_wb_data.delete();
    obs_br_taken.delete();
    obs_br_target.delete();
    @(posedge i_clk);
    #2;
endtask

`include "nand_cpu_tb_tests.svh"

initial begin
    void'($urandom(42));
    i_reset = 1'b1;
    i_instr_valid = 1'b0;
    i_instr = '0;
    mismatch_count = 0;
    other_error_count = 0;
    model_reset();
    repeat (RESET_CYCLES - 1) @(posedge i_clk);
    @(negedge i_clk);
    check_reset_outputs("during reset");
    @(posedge i_clk);
    #2;
    i_reset = 1'b0;
    @(negedge i_clk);
    check_reset_outputs("right after reset");
    @(posedge i_clk);
    #2;

    test_alu_ops();
    test_forwarding();
    test_memory();
    test_branches();
    test_halt();

    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_error_count);
    if (mismatch_count == 0 && other_error_count == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule
